//--- Bender.yml
package:
  name: intc

sources:
  # Package first, the RTL modules depend on its types
  - design/intc_pkg.sv
  - design/intc_edge_capture.sv
  - design/intc_pending_accum.sv
  - design/intc_priority_encoder.sv
  - design/intc_ctrl.sv
  - design/intc_top.sv

  - target: test
    files:
      - test/intc_tb.sv

//--- design/intc_ctrl.sv
// Mask register and request FSM
`default_nettype none
`timescale 1ns/10ps

module intc_ctrl import intc_pkg::*; (
    input  wire        clk_i,
    input  wire        rst_n_i,
    input  wire        cfg_we_i,
    input  irq_vec_t   cfg_mask_i,
    input  wire        ack_i,
    input  irq_claim_t claim_i,
    output irq_vec_t   mask_o,
    output logic       clr_en_o,
    output irq_id_t    clr_id_o,
    output logic       irq_o,
    output irq_id_t    irq_id_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    irq_vec_t    mask_q;
    irq_id_t     irq_id_q;
    logic        take_claim;
    logic        ack_hit;

    // Mask register, all sources blocked out of reset.
    // A write takes effect at the sampling edge, so events at that
    // edge still see the old mask.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mask_q <= '1;
        end else if (cfg_we_i) begin
            mask_q <= cfg_mask_i;
        end
    end

    // Idle with work pending, latch the claim
    assign take_claim = (state_q == ST_IDLE) && claim_i.found;

    // Acknowledge only counts while a request is presented
    assign ack_hit = (state_q == ST_PRESENT) && ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (claim_i.found) begin
                    state_d = ST_PRESENT;
                end
            end
            ST_PRESENT: begin
                // Back to idle for at least one cycle before the next request
                if (ack_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Presented index holds until the next claim is taken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_id_q <= '0;
        end else if (take_claim) begin
            irq_id_q <= claim_i.id;
        end
    end

    assign mask_o   = mask_q;
    assign irq_o    = (state_q == ST_PRESENT);
    assign irq_id_o = irq_id_q;

    // Clear request for the presented source, same cycle as the ack
    assign clr_en_o = ack_hit;
    assign clr_id_o = irq_id_q;

endmodule

`default_nettype wire

//--- design/intc_edge_capture.sv
// Rising edge detector
`default_nettype none
`timescale 1ns/10ps

module intc_edge_capture import intc_pkg::*; (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  irq_vec_t src_i,
    output irq_vec_t event_o
);

    // Sample of the sources from the previous clock
    irq_vec_t src_prev_q;

    // Sources are assumed to be synchronous to clk_i already.
    // A zero reset value lets a source that is high right after reset
    // count as an event on the first edge.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_prev_q <= '0;
        end else begin
            src_prev_q <= src_i;
        end
    end

    // Event when the source is high now and was low last cycle
    assign event_o = src_i & ~src_prev_q;

endmodule

`default_nettype wire

//--- design/intc_pending_accum.sv
// Masked pending accumulator
`default_nettype none
`timescale 1ns/10ps

module intc_pending_accum import intc_pkg::*; (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  irq_vec_t event_i,
    input  irq_vec_t mask_i,
    input  wire      clr_en_i,
    input  irq_id_t  clr_id_i,
    output irq_vec_t pending_o
);

    irq_vec_t pending_q;
    irq_vec_t pending_d;
    irq_vec_t set_vec;
    irq_vec_t clr_vec;

    // Mask acts at the input, masked events are dropped.
    // Bits already pending are not affected by the mask.
    assign set_vec = event_i & ~mask_i;

    // One-hot clear for the acknowledged source
    always_comb begin
        clr_vec = '0;
        if (clr_en_i) begin
            clr_vec[clr_id_i] = 1'b1;
        end
    end

    // Set is applied after the clear, so a new event on the
    // acknowledged source wins at the same edge
    assign pending_d = (pending_q & ~clr_vec) | set_vec;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

//--- design/intc_pkg.sv
// Interrupt controller shared types
`default_nettype none

package intc_pkg;

    // Number of interrupt sources and the width of a source index
    localparam int N_SRC = 8;
    localparam int ID_W  = 3;

    // One bit per source
    // Used for sources, events, mask and pending bits
    typedef logic [N_SRC-1:0] irq_vec_t;

    // Index of a single source
    typedef logic [ID_W-1:0] irq_id_t;

    // Result of the priority scan
    typedef struct packed {
        logic    found;
        irq_id_t id;
    } irq_claim_t;

    // Request presentation FSM
    typedef enum logic {
        ST_IDLE    = 1'b0,
        ST_PRESENT = 1'b1
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/intc_priority_encoder.sv
// Lowest index priority encoder
`default_nettype none
`timescale 1ns/10ps

module intc_priority_encoder import intc_pkg::*; (
    input  irq_vec_t   pending_i,
    output irq_claim_t claim_o
);

    irq_claim_t claim;

    // Scan upwards, the first set bit is taken and later
    // bits are ignored once found is set
    always_comb begin
        claim.found = 1'b0;
        claim.id    = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (pending_i[i] && !claim.found) begin
                claim.found = 1'b1;
                claim.id    = irq_id_t'(i);
            end
        end
    end

    assign claim_o = claim;

endmodule

`default_nettype wire

//--- design/intc_top.sv
// Interrupt controller top level
`default_nettype none
`timescale 1ns/10ps

module intc_top import intc_pkg::*; (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  irq_vec_t irq_src_i,
    input  wire      cfg_we_i,
    input  irq_vec_t cfg_mask_i,
    input  wire      ack_i,
    output logic     irq_o,
    output irq_id_t  irq_id_o,
    output irq_vec_t pending_o,
    output irq_vec_t mask_o
);

    irq_vec_t   event_vec;
    irq_vec_t   mask_vec;
    irq_vec_t   pending_vec;
    irq_claim_t claim;
    logic       clr_en;
    irq_id_t    clr_id;

    intc_edge_capture intc_edge_capture_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .src_i   (irq_src_i),
        .event_o (event_vec)
    );

    intc_pending_accum intc_pending_accum_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .event_i   (event_vec),
        .mask_i    (mask_vec),
        .clr_en_i  (clr_en),
        .clr_id_i  (clr_id),
        .pending_o (pending_vec)
    );

    intc_priority_encoder intc_priority_encoder_i (
        .pending_i (pending_vec),
        .claim_o   (claim)
    );

    intc_ctrl intc_ctrl_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_mask_i (cfg_mask_i),
        .ack_i      (ack_i),
        .claim_i    (claim),
        .mask_o     (mask_vec),
        .clr_en_o   (clr_en),
        .clr_id_o   (clr_id),
        .irq_o      (irq_o),
        .irq_id_o   (irq_id_o)
    );

    assign pending_o = pending_vec;
    assign mask_o    = mask_vec;

endmodule

`default_nettype wire

//--- intc.f
design/intc_pkg.sv
design/intc_edge_capture.sv
design/intc_pending_accum.sv
design/intc_priority_encoder.sv
design/intc_ctrl.sv
design/intc_top.sv
test/intc_tb.sv

//--- test/intc_tb.sv
// Interrupt controller testbench
`default_nettype none
`timescale 1ns/10ps

module intc_tb import intc_pkg::*; ();

    localparam int N_CYCLES   = 3000;
    localparam int MAX_CYCLES = 4000;
    // Window where ack stays low to build up back-pressure
    localparam int HOLD_START = 1200;
    localparam int HOLD_END   = 1400;

    logic       clk_i;
    logic       rst_n_i;
    irq_vec_t   src;
    logic       cfg_we;
    irq_vec_t   cfg_mask;
    logic       ack;
    logic       irq;
    irq_id_t    irq_id;
    irq_vec_t   pending;
    irq_vec_t   mask;

    // Reference model state
    irq_vec_t    m_prev;
    irq_vec_t    m_pending;
    irq_vec_t    m_mask;
    ctrl_state_e m_state;
    irq_id_t     m_irq_id;

    logic [15:0] lfsr_q;
    int          cycle_cnt;

    intc_top intc_top_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .irq_src_i  (src),
        .cfg_we_i   (cfg_we),
        .cfg_mask_i (cfg_mask),
        .ack_i      (ack),
        .irq_o      (irq),
        .irq_id_o   (irq_id),
        .pending_o  (pending),
        .mask_o     (mask)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // 16-bit Galois LFSR, maximal length taps
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q  = lfsr_step(lfsr_q);
        end
    endtask

    // Lowest set bit, scanned from the top down
    function automatic irq_claim_t lowest_pending(input irq_vec_t p);
        irq_claim_t c;
        c.found = 1'b0;
        c.id    = '0;
        for (int i = N_SRC - 1; i >= 0; i--) begin
            if (p[i]) begin
                c.found = 1'b1;
                c.id    = irq_id_t'(i);
            end
        end
        return c;
    endfunction

    task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One rising edge of the model, using the inputs the DUT just sampled
    task automatic model_step();
        irq_vec_t   ev;
        irq_vec_t   clr;
        irq_claim_t claim;
        ev    = src & ~m_prev;
        clr   = '0;
        claim = lowest_pending(m_pending);
        if (m_state == ST_PRESENT && ack) begin
            clr[m_irq_id] = 1'b1;
        end
        // Set wins over clear
        m_pending = (m_pending & ~clr) | (ev & ~m_mask);
        if (cfg_we) begin
            m_mask = cfg_mask;
        end
        if (m_state == ST_IDLE && claim.found) begin
            m_state  = ST_PRESENT;
            m_irq_id = claim.id;
        end else if (m_state == ST_PRESENT && ack) begin
            m_state = ST_IDLE;
        end
        m_prev = src;
    endtask

    task automatic compare_outputs();
        check_bit("irq_o", m_state == ST_PRESENT, irq);
        check_id("irq_id_o", m_irq_id, irq_id);
        check_vec("pending_o", m_pending, pending);
        check_vec("mask_o", m_mask, mask);
    endtask

    task automatic drive_inputs(input int cyc);
        logic [7:0] bits;
        irq_vec_t   next_src;
        next_src = src;
        // Each source toggles with probability 1/4
        for (int s = 0; s < N_SRC; s++) begin
            take_bits(2, bits);
            if (bits[1:0] == 2'b00) begin
                next_src[s] = ~next_src[s];
            end
        end
        take_bits(5, bits);
        cfg_we = (bits[4:0] == 5'b0);
        take_bits(8, bits);
        cfg_mask = bits;
        if (cyc >= HOLD_START && cyc < HOLD_END) begin
            ack = 1'b0;
        end else if (m_state == ST_PRESENT) begin
            take_bits(2, bits);
            ack = (bits[1:0] == 2'b00);
        end else begin
            // Occasional stray ack while idle
            take_bits(5, bits);
            ack = (bits[4:0] == 5'b0);
        end
        src = next_src;
    endtask

    initial begin : stimulus
        lfsr_q    = 16'd26509;
        rst_n_i   = 1'b0;
        src       = '0;
        cfg_we    = 1'b0;
        cfg_mask  = '0;
        ack       = 1'b0;
        m_prev    = '0;
        m_pending = '0;
        m_mask    = '1;
        m_state   = ST_IDLE;
        m_irq_id  = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        // Reset values before the first active edge
        compare_outputs();
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            drive_inputs(cyc);
            @(negedge clk_i);
            model_step();
            compare_outputs();
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Run limit, stimulus length plus margin
    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "Run timed out");
    end

endmodule

`default_nettype wire
